//--- source/pu_arith_pkg.sv
`default_nettype none

package pu_arith_pkg;

    // sample and weight width unless the top level overrides it
    localparam int DEFAULT_OP_WIDTH = 16;

    localparam int PRECISION_FRAC = 8; // fraction bits, products shift right by this

    localparam int ACC_WIDTH = 48; // sum of shifted products, low bits give the result

endpackage

`default_nettype wire

//--- source/pu_regs_pkg.sv
`default_nettype none

package pu_regs_pkg;

    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    localparam logic [APB_ADDR_WIDTH-1:0] CTRL_ADDR        = 8'h00;
    localparam logic [APB_ADDR_WIDTH-1:0] KWIDTH_ADDR      = 8'h04;
    localparam logic [APB_ADDR_WIDTH-1:0] IWIDTH_ADDR      = 8'h08;
    localparam logic [APB_ADDR_WIDTH-1:0] STATUS_ADDR      = 8'h0C; // read only
    localparam logic [APB_ADDR_WIDTH-1:0] WEIGHT_BASE_ADDR = 8'h20; // weight k at +4*k

    localparam int CTRL_START_BIT  = 0; // write 1 to start, reads 0
    localparam int CTRL_POOL_BIT   = 1;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    localparam int IWIDTH_BITS = 12; // input row width field
    localparam int KWIDTH_BITS = 4;  // kernel width field

endpackage

`default_nettype wire

//--- source/pu_apb_regs.sv
`default_nettype none

module pu_apb_regs
    import pu_regs_pkg::*;
#(
    parameter int OP_WIDTH   = 16,
    parameter int MAX_KERNEL = 8
)
(
    input  wire                            clk,
    input  wire                            reset,
    input  wire [APB_ADDR_WIDTH-1:0]       paddr,
    input  wire                            psel,
    input  wire                            penable,
    input  wire                            pwrite,
    input  wire [APB_DATA_WIDTH-1:0]       pwdata,
    output logic [APB_DATA_WIDTH-1:0]      prdata,
    input  wire                            busy,
    input  wire                            done,
    output logic                           start_pulse,
    output logic                           pool_enable,
    output logic [KWIDTH_BITS-1:0]         kernel_width,
    output logic [IWIDTH_BITS-1:0]         input_width,
    output logic signed [OP_WIDTH-1:0]     weights [MAX_KERNEL]
);

    localparam int IDX_BITS = (MAX_KERNEL > 1) ? $clog2(MAX_KERNEL) : 1;

    logic                          wr_en;
    logic                          locked;
    logic                          run_ok;
    logic                          is_weight;
    logic [APB_ADDR_WIDTH-1:0]     woff;
    logic [APB_ADDR_WIDTH-3:0]     wword;
    logic [IDX_BITS-1:0]           widx;

    assign wr_en  = psel && penable && pwrite; // zero-wait access phase
    assign locked = busy || start_pulse;       // frozen from launch to done

    // a run needs a kernel and at least one full window
    assign run_ok = (kernel_width != '0) && (input_width >= IWIDTH_BITS'(kernel_width));

    assign woff      = paddr - WEIGHT_BASE_ADDR;
    assign wword     = woff[APB_ADDR_WIDTH-1:2];
    assign widx      = wword[IDX_BITS-1:0];
    assign is_weight = (paddr >= WEIGHT_BASE_ADDR) && (woff[1:0] == 2'b00)
                       && (int'(wword) < MAX_KERNEL);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            start_pulse  <= 1'b0;
            pool_enable  <= 1'b0;
            kernel_width <= '0;
            input_width  <= '0;
            for (int k = 0; k < MAX_KERNEL; k++)
                weights[k] <= '0;
        end
        else
        begin
            start_pulse <= 1'b0;
            if (wr_en && !locked)
            begin
                if (paddr == CTRL_ADDR)
                begin
                    pool_enable <= pwdata[CTRL_POOL_BIT];
                    start_pulse <= pwdata[CTRL_START_BIT] && run_ok;
                end
                if ((paddr == KWIDTH_ADDR) && (pwdata >= 1) && (pwdata <= MAX_KERNEL))
                    kernel_width <= pwdata[KWIDTH_BITS-1:0];
                if ((paddr == IWIDTH_ADDR) && (pwdata >= APB_DATA_WIDTH'(kernel_width))
                    && (pwdata < 2**IWIDTH_BITS))
                    input_width <= pwdata[IWIDTH_BITS-1:0];
                if (is_weight)
                    weights[widx] <= pwdata[OP_WIDTH-1:0];
            end
        end
    end

    always_comb
    begin
        prdata = '0;
        if (is_weight)
            prdata = APB_DATA_WIDTH'(weights[widx]); // sign extended
        else
        begin
            case (paddr)
                CTRL_ADDR:   prdata[CTRL_POOL_BIT] = pool_enable; // start bit reads 0
                KWIDTH_ADDR: prdata[KWIDTH_BITS-1:0] = kernel_width;
                IWIDTH_ADDR: prdata[IWIDTH_BITS-1:0] = input_width;
                STATUS_ADDR:
                begin
                    prdata[STATUS_BUSY_BIT] = busy;
                    prdata[STATUS_DONE_BIT] = done;
                end
                default:     prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/pu_controller.sv
`default_nettype none

module pu_controller
    import pu_regs_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        start_pulse,
    input  wire [IWIDTH_BITS-1:0]      input_width,
    input  wire                        rd_ready,
    output logic                       rd_req,
    output logic                       sample_valid,
    output logic                       sample_last,
    input  wire                        result_last,
    output logic                       busy,
    output logic                       done
);

    typedef enum logic [1:0]
    {
        IDLE,
        FETCH,
        DRAIN
    } state_t;

    state_t                    state;
    logic [IWIDTH_BITS-1:0]    sample_cnt; // samples accepted this run

    assign busy         = (state != IDLE);
    assign rd_req       = (state == FETCH);
    assign sample_valid = rd_req && rd_ready;
    assign sample_last  = sample_valid && (sample_cnt == input_width - 1'b1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= IDLE;
            sample_cnt <= '0;
            done       <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start_pulse)
                    begin
                        state      <= FETCH;
                        sample_cnt <= '0;
                        done       <= 1'b0;
                    end
                end
                FETCH:
                begin
                    if (sample_valid)
                    begin
                        sample_cnt <= sample_cnt + 1'b1;
                        if (sample_last)
                            state <= DRAIN; // row fully read
                    end
                end
                DRAIN:
                begin
                    // results still in flight through mac and pool
                    if (result_last)
                    begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/pu_conv_mac.sv
`default_nettype none

module pu_conv_mac
    import pu_arith_pkg::*, pu_regs_pkg::*;
#(
    parameter int OP_WIDTH   = 16,
    parameter int MAX_KERNEL = 8
)
(
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            sample_valid,
    input  wire                            sample_last,
    input  wire signed [OP_WIDTH-1:0]      rd_data,
    input  wire signed [OP_WIDTH-1:0]      weights [MAX_KERNEL],
    input  wire [KWIDTH_BITS-1:0]          kernel_width,
    output logic                           conv_valid,
    output logic signed [OP_WIDTH-1:0]     conv_data,
    output logic                           conv_last
);

    localparam int PROD_WIDTH = 2 * OP_WIDTH;

    logic signed [OP_WIDTH-1:0]      window    [MAX_KERNEL];
    logic signed [OP_WIDTH-1:0]      next_win  [MAX_KERNEL];
    logic signed [PROD_WIDTH-1:0]    prod_next [MAX_KERNEL];
    logic signed [PROD_WIDTH-1:0]    prod_q    [MAX_KERNEL];
    logic signed [ACC_WIDTH-1:0]     acc;
    logic [KWIDTH_BITS-1:0]          fill_cnt;
    logic [KWIDTH_BITS:0]            fill_next;
    logic                            window_full;
    logic                            start_result;
    logic                            s1_valid;
    logic                            s1_last;

    assign fill_next    = {1'b0, fill_cnt} + 1'b1;
    assign window_full  = (fill_next >= {1'b0, kernel_width}); // this sample completes K
    assign start_result = sample_valid && window_full;

    // window slot 0 is the oldest of the newest K samples, new sample enters at K-1
    always_comb
    begin
        for (int i = 0; i < MAX_KERNEL; i++)
        begin
            if (i == int'(kernel_width) - 1)
                next_win[i] = rd_data;
            else if (i < MAX_KERNEL - 1)
                next_win[i] = window[i + 1];
            else
                next_win[i] = window[i];
        end
    end

    always_comb
    begin
        logic signed [PROD_WIDTH-1:0] full;
        for (int k = 0; k < MAX_KERNEL; k++)
        begin
            full = PROD_WIDTH'(weights[k]) * PROD_WIDTH'(next_win[k]);
            prod_next[k] = (k < int'(kernel_width)) ? (full >>> PRECISION_FRAC) : '0;
        end
    end

    always_comb
    begin
        acc = '0;
        for (int k = 0; k < MAX_KERNEL; k++)
            acc = acc + ACC_WIDTH'(prod_q[k]);
    end

    always_ff @(posedge clk)
    begin
        if (sample_valid)
            window <= next_win;
        if (start_result)
            prod_q <= prod_next; // stage 1
        if (s1_valid)
            conv_data <= acc[OP_WIDTH-1:0]; // stage 2, truncated sum
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fill_cnt   <= '0;
            s1_valid   <= 1'b0;
            s1_last    <= 1'b0;
            conv_valid <= 1'b0;
            conv_last  <= 1'b0;
        end
        else
        begin
            s1_valid   <= start_result;
            s1_last    <= sample_valid && sample_last;
            conv_valid <= s1_valid;
            conv_last  <= s1_valid && s1_last;
            if (sample_valid)
            begin
                if (sample_last)
                    fill_cnt <= '0; // next row starts empty
                else if (!window_full)
                    fill_cnt <= fill_next[KWIDTH_BITS-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/pu_max_pool.sv
`default_nettype none

module pu_max_pool #(
    parameter int OP_WIDTH = 16
)
(
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            pool_enable,
    input  wire                            conv_valid,
    input  wire signed [OP_WIDTH-1:0]      conv_data,
    input  wire                            conv_last,
    output logic                           wr_req,
    output logic signed [OP_WIDTH-1:0]     wr_data,
    output logic                           result_last
);

    logic                          have_held; // even result waiting for its partner
    logic signed [OP_WIDTH-1:0]    held_data;
    logic signed [OP_WIDTH-1:0]    pair_max;
    logic                          emit;

    assign pair_max = (conv_data > held_data) ? conv_data : held_data;

    // unpaired final result goes out alone
    assign emit = !pool_enable || have_held || conv_last;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_req      <= 1'b0;
            result_last <= 1'b0;
            have_held   <= 1'b0;
        end
        else
        begin
            wr_req      <= conv_valid && emit;
            result_last <= conv_valid && emit && conv_last;
            if (conv_valid)
                have_held <= !emit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (conv_valid && !emit)
            held_data <= conv_data;
        if (conv_valid && emit)
            wr_data <= (pool_enable && have_held) ? pair_max : conv_data;
    end

endmodule

`default_nettype wire

//--- source/pu_top.sv
`default_nettype none

module pu_top
    import pu_arith_pkg::*, pu_regs_pkg::*;
#(
    parameter int OP_WIDTH   = DEFAULT_OP_WIDTH,
    parameter int MAX_KERNEL = 8
)
(
    input  wire                            clk,
    input  wire                            reset,
    input  wire [APB_ADDR_WIDTH-1:0]       paddr,
    input  wire                            psel,
    input  wire                            penable,
    input  wire                            pwrite,
    input  wire [APB_DATA_WIDTH-1:0]       pwdata,
    output logic [APB_DATA_WIDTH-1:0]      prdata,
    input  wire                            rd_ready,
    input  wire signed [OP_WIDTH-1:0]      rd_data,
    output logic                           rd_req,
    output logic                           wr_req,
    output logic signed [OP_WIDTH-1:0]     wr_data
);

    logic                          start_pulse;
    logic                          pool_enable;
    logic [KWIDTH_BITS-1:0]        kernel_width;
    logic [IWIDTH_BITS-1:0]        input_width;
    logic signed [OP_WIDTH-1:0]    weights [MAX_KERNEL];
    logic                          busy;
    logic                          done;
    logic                          sample_valid;
    logic                          sample_last;
    logic                          conv_valid;
    logic signed [OP_WIDTH-1:0]    conv_data;
    logic                          conv_last;
    logic                          result_last;

    pu_apb_regs #(
        .OP_WIDTH     (OP_WIDTH),
        .MAX_KERNEL   (MAX_KERNEL)
    ) regs_i (
        .clk          (clk),
        .reset        (reset),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .busy         (busy),
        .done         (done),
        .start_pulse  (start_pulse),
        .pool_enable  (pool_enable),
        .kernel_width (kernel_width),
        .input_width  (input_width),
        .weights      (weights)
    );

    pu_controller ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .start_pulse  (start_pulse),
        .input_width  (input_width),
        .rd_ready     (rd_ready),
        .rd_req       (rd_req),
        .sample_valid (sample_valid),
        .sample_last  (sample_last),
        .result_last  (result_last),
        .busy         (busy),
        .done         (done)
    );

    pu_conv_mac #(
        .OP_WIDTH     (OP_WIDTH),
        .MAX_KERNEL   (MAX_KERNEL)
    ) mac_i (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_last  (sample_last),
        .rd_data      (rd_data),
        .weights      (weights),
        .kernel_width (kernel_width),
        .conv_valid   (conv_valid),
        .conv_data    (conv_data),
        .conv_last    (conv_last)
    );

    pu_max_pool #(
        .OP_WIDTH     (OP_WIDTH)
    ) pool_i (
        .clk          (clk),
        .reset        (reset),
        .pool_enable  (pool_enable),
        .conv_valid   (conv_valid),
        .conv_data    (conv_data),
        .conv_last    (conv_last),
        .wr_req       (wr_req),
        .wr_data      (wr_data),
        .result_last  (result_last)
    );

endmodule

`default_nettype wire

//--- verification/pu_assert.sv
`default_nettype none

module pu_assert
(
    input wire clk,
    input wire reset,
    input wire start_pulse,
    input wire rd_req,
    input wire busy,
    input wire done,
    input wire result_last
);

    // samples only requested inside a run, which opens the cycle after start_pulse
    rd_req_opens_run: assert property (@(posedge clk) disable iff (reset)
        $rose(rd_req) |-> $past(start_pulse))
        else $error("rd_req rose without a start of a run");

    busy_done_exclusive: assert property (@(posedge clk) disable iff (reset) !(busy && done))
        else $error("busy and done high in the same cycle");

    // drain is the only busy state without rd_req
    last_only_in_drain: assert property (@(posedge clk) disable iff (reset)
        result_last |-> (busy && !rd_req))
        else $error("result_last seen outside the drain state");

endmodule

bind pu_controller pu_assert assert_i
(
    .clk         (clk),
    .reset       (reset),
    .start_pulse (start_pulse),
    .rd_req      (rd_req),
    .busy        (busy),
    .done        (done),
    .result_last (result_last)
);

`default_nettype wire

//--- verification/pu_tb.sv
`default_nettype none

module pu_tb
    import pu_regs_pkg::*, pu_arith_pkg::*;
();

    localparam int OP_WIDTH        = 16;
    localparam int MAX_KERNEL      = 8;
    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int ROW_WIDTH_SUM   = 10 + 12 + 12 + 8 + 2 * 10 + 2 * 16; // all rows fed
    localparam int WATCHDOG_CYCLES = ROW_WIDTH_SUM * 4 + 2000;

    logic                          clk;
    logic                          reset;
    logic [APB_ADDR_WIDTH-1:0]     paddr;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [APB_DATA_WIDTH-1:0]     pwdata;
    logic [APB_DATA_WIDTH-1:0]     prdata;
    logic                          rd_ready;
    logic signed [OP_WIDTH-1:0]    rd_data;
    logic                          rd_req;
    logic                          wr_req;
    logic signed [OP_WIDTH-1:0]    wr_data;

    logic signed [OP_WIDTH-1:0]    wt_m [MAX_KERNEL];
    logic signed [OP_WIDTH-1:0]    smp_m [256];
    int                            accept_edge [256];
    logic signed [OP_WIDTH-1:0]    wr_seen [$];
    int                            wr_edge [$];
    int                            cycle_cnt = 0;
    int                            err_cnt = 0;
    int                            check_cnt = 0;

    pu_top #(
        .OP_WIDTH   (OP_WIDTH),
        .MAX_KERNEL (MAX_KERNEL)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .rd_ready   (rd_ready),
        .rd_data    (rd_data),
        .rd_req     (rd_req),
        .wr_req     (wr_req),
        .wr_data    (wr_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // wr_req is registered, steady at the falling edge
    always @(negedge clk)
    begin
        if (wr_req)
        begin
            wr_seen.push_back(wr_data);
            wr_edge.push_back(cycle_cnt + 1); // edge that takes the write
        end
    end

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        check_cnt++;
        assert (actual === expected)
        else
        begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        check_cnt++;
        assert (cond)
        else
        begin
            $display("%s", what);
            err_cnt++;
        end
    endtask

    task automatic write_reg(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        data    = prdata; // address settled a cycle ago
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic signed [OP_WIDTH-1:0] model_result(input int k, input int j);
        longint sum;
        longint prod;
        sum = 0;
        for (int i = 0; i < k; i++)
        begin
            prod = longint'(wt_m[i]) * longint'(smp_m[j + i]);
            sum  = sum + (prod >>> PRECISION_FRAC);
        end
        return sum[OP_WIDTH-1:0];
    endfunction

    task automatic load_case(input int k, input int w);
        for (int i = 0; i < MAX_KERNEL; i++)
        begin
            wt_m[i] = (i < k) ? OP_WIDTH'($urandom) : '0;
            write_reg(WEIGHT_BASE_ADDR + 8'(4 * i), 32'(wt_m[i]));
        end
        for (int i = 0; i < w; i++)
            smp_m[i] = OP_WIDTH'($urandom);
        write_reg(KWIDTH_ADDR, k);
        write_reg(IWIDTH_ADDR, w);
    endtask

    task automatic start_run(input bit pool);
        wr_seen.delete();
        wr_edge.delete();
        write_reg(CTRL_ADDR, {30'd0, pool, 1'b1});
    endtask

    task automatic feed_row(input int w, input bit back_pressure);
        int idx;
        idx = 0;
        while (idx < w)
        begin
            @(negedge clk);
            rd_ready = back_pressure ? 1'($urandom % 2) : 1'b1;
            rd_data  = smp_m[idx];
            if (rd_req && rd_ready)
            begin
                accept_edge[idx] = cycle_cnt + 1; // sample moves at the next rising edge
                idx++;
            end
        end
        @(negedge clk);
        rd_ready = 1'b0;
    endtask

    task automatic check_run(input int k, input int w, input bit pool);
        logic signed [OP_WIDTH-1:0] res [256];
        logic signed [OP_WIDTH-1:0] exp_val;
        logic [31:0]                status;
        int                         n;
        int                         n_wr;
        int                         r;
        int                         tries;
        n = w - k + 1;
        for (int j = 0; j < n; j++)
            res[j] = model_result(k, j);
        n_wr   = pool ? (n + 1) / 2 : n;
        tries  = 0;
        status = '0;
        while (!status[STATUS_DONE_BIT] && tries < 50)
        begin
            read_reg(STATUS_ADDR, status);
            tries++;
        end
        expect_true(status[STATUS_DONE_BIT], "done was never set at the end of the run");
        expect_equal("busy", 32'd0, 32'(status[STATUS_BUSY_BIT]));
        expect_equal("rd_req", 32'd0, 32'(rd_req));
        expect_true(wr_seen.size() == n_wr,
                    $sformatf("expected %0d writes but saw %0d", n_wr, wr_seen.size()));
        for (int i = 0; i < n_wr && i < wr_seen.size(); i++)
        begin
            r = pool ? ((2 * i + 1 < n) ? 2 * i + 1 : n - 1) : i;
            exp_val = res[r];
            if (pool && (r == 2 * i + 1) && (res[2 * i] > res[r]))
                exp_val = res[2 * i];
            expect_equal("wr_data", 32'(exp_val), 32'(wr_seen[i]));
            expect_equal("wr_req edge", accept_edge[r + k - 1] + 3, wr_edge[i]);
        end
    endtask

    task automatic run_row(input int k, input int w, input bit pool, input bit back_pressure);
        start_run(pool);
        feed_row(w, back_pressure);
        check_run(k, w, pool);
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        read_reg(STATUS_ADDR, data);
        expect_equal("status", 32'd0, data);
        read_reg(CTRL_ADDR, data);
        expect_equal("ctrl", 32'd0, data);
        read_reg(KWIDTH_ADDR, data);
        expect_equal("kwidth", 32'd0, data);
        read_reg(IWIDTH_ADDR, data);
        expect_equal("iwidth", 32'd0, data);
        for (int i = 0; i < MAX_KERNEL; i++)
        begin
            read_reg(WEIGHT_BASE_ADDR + 8'(4 * i), data);
            expect_equal($sformatf("weight[%0d]", i), 32'd0, data);
        end
        expect_equal("rd_req", 32'd0, 32'(rd_req));
        expect_equal("wr_req", 32'd0, 32'(wr_req));
    endtask

    task automatic test_register_access();
        logic [31:0] data;
        write_reg(WEIGHT_BASE_ADDR, 32'h0000_8123);
        read_reg(WEIGHT_BASE_ADDR, data);
        expect_equal("weight[0]", 32'hFFFF_8123, data); // sign extended
        write_reg(WEIGHT_BASE_ADDR + 8'h1C, 32'h0000_0345);
        read_reg(WEIGHT_BASE_ADDR + 8'h1C, data);
        expect_equal("weight[7]", 32'h0000_0345, data);
        write_reg(KWIDTH_ADDR, 3);
        write_reg(KWIDTH_ADDR, 0);
        write_reg(KWIDTH_ADDR, MAX_KERNEL + 1);
        read_reg(KWIDTH_ADDR, data);
        expect_equal("kwidth", 32'd3, data);
        write_reg(IWIDTH_ADDR, 10);
        write_reg(IWIDTH_ADDR, 2);
        read_reg(IWIDTH_ADDR, data);
        expect_equal("iwidth", 32'd10, data);

        // config is frozen while the row is pending
        load_case(3, 10);
        start_run(1'b0);
        write_reg(KWIDTH_ADDR, 2);
        write_reg(IWIDTH_ADDR, 20);
        write_reg(WEIGHT_BASE_ADDR, 32'h0000_1111);
        write_reg(CTRL_ADDR, 32'h3);
        read_reg(STATUS_ADDR, data);
        expect_equal("status", 32'h1, data);
        read_reg(KWIDTH_ADDR, data);
        expect_equal("kwidth", 32'd3, data);
        read_reg(IWIDTH_ADDR, data);
        expect_equal("iwidth", 32'd10, data);
        read_reg(WEIGHT_BASE_ADDR, data);
        expect_equal("weight[0]", 32'(wt_m[0]), data);
        read_reg(CTRL_ADDR, data);
        expect_equal("ctrl", 32'd0, data);
        feed_row(10, 1'b0);
        check_run(3, 10, 1'b0);
    endtask

    task automatic test_kernel_extremes();
        load_case(1, 10);
        run_row(1, 10, 1'b0, 1'b0);
        run_row(1, 10, 1'b0, 1'b0); // restart after done
        load_case(MAX_KERNEL, 16);
        run_row(MAX_KERNEL, 16, 1'b0, 1'b0);
        run_row(MAX_KERNEL, 16, 1'b0, 1'b0);
    endtask

    initial
    begin
        void'($urandom(38124));
        reset    = 1'b1;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        rd_ready = 1'b0;
        rd_data  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_register_access();
        load_case(3, 12);
        run_row(3, 12, 1'b0, 1'b0);
        run_row(3, 12, 1'b0, 1'b1); // same row, random rd_ready
        load_case(2, 8);
        run_row(2, 8, 1'b1, 1'b0);
        test_kernel_extremes();

        $display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("summary: %0d checks, %0d errors", check_cnt, err_cnt + 1);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/pu_arith_pkg.sv
source/pu_regs_pkg.sv
source/pu_apb_regs.sv
source/pu_controller.sv
source/pu_conv_mac.sv
source/pu_max_pool.sv
source/pu_top.sv
verification/pu_assert.sv
verification/pu_tb.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module pu_tb -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vpu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi

exit 0
